// File: list.f
hdl/cache_pkg.sv
hdl/cache_line_store.sv
hdl/way_select.sv
hdl/line_builder.sv
hdl/cache_ctrl_fsm.sv
hdl/cache_top.sv
sim/tb_cache_top.sv

// File: Bender.yml
package:
  name: cache_top

sources:
  - files:
      - hdl/cache_pkg.sv
      - hdl/cache_line_store.sv
      - hdl/way_select.sv
      - hdl/line_builder.sv
      - hdl/cache_ctrl_fsm.sv
      - hdl/cache_top.sv
  - target: simulation
    files:
      - sim/tb_cache_top.sv

// File: sim/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

  localparam int SET_BITS   = 4;
  localparam int NUM_SETS   = 1 << SET_BITS;
  localparam int OFF_W      = 4;                       // Byte offset within a block
  localparam int TAG_W      = 32 - SET_BITS - OFF_W;
  localparam int OLDEST_AGE = 3;
  localparam int NUM_DIRECTED   = 13;
  localparam int NUM_RANDOM     = 300;
  localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 40 + 200;

  typedef logic [31:0]  word_t;
  typedef logic [127:0] block_t;

  typedef struct {
    string  name;
    word_t  addr;
    logic   rw;
    logic   hit;
    logic   wb;
    word_t  wb_addr;
    block_t wb_blk;
    word_t  fill_addr;
    word_t  rdata;
  } exp_t;

  typedef struct {
    logic   rw;
    word_t  addr;
    block_t data;
  } xfer_t;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   cpu_req_enable;
  logic   cpu_req_ready;
  logic   cpu_req_rw;
  word_t  cpu_req_addr;
  word_t  cpu_req_datain;
  logic   cpu_res_ready;
  word_t  cpu_res_dataout;
  logic   mem_req_enable;
  logic   mem_req_rw;
  word_t  mem_req_addr;
  block_t mem_req_dataout;
  block_t mem_req_datain;
  logic   mem_req_ready;

  word_t mem_words    [word_t];   // Main memory, written words only
  word_t shadow_words [word_t];   // Latest CPU-visible values

  bit               ref_valid [NUM_SETS][4];
  bit               ref_dirty [NUM_SETS][4];
  logic [TAG_W-1:0] ref_tag   [NUM_SETS][4];
  int               ref_age   [NUM_SETS][4];

  exp_t  exp_q [$];
  xfer_t xfer_q [$];
  xfer_t cap;

  word_t stim_rng;
  word_t mem_rng;
  bit    in_xfer = 1'b0;
  int    stall_left = 0;
  word_t held_addr;
  logic  held_rw;
  int    busy_cycles = 0;   // Cycles since the controller left IDLE
  int    n_checks = 0;
  int    data_errors = 0;
  int    mem_errors = 0;
  int    proto_errors = 0;

  always #4 clk = ~clk;

  cache_top #(.SET_BITS(SET_BITS)) i_dut (
    .clk, .rst_n,
    .cpu_req_enable, .cpu_req_ready, .cpu_req_rw, .cpu_req_addr, .cpu_req_datain,
    .cpu_res_ready, .cpu_res_dataout,
    .mem_req_enable, .mem_req_rw, .mem_req_addr, .mem_req_dataout,
    .mem_req_datain, .mem_req_ready
  );

  function automatic word_t xorshift32(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Contents of a word that was never written
  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  function automatic word_t mem_word(input word_t addr);
    if (mem_words.exists(addr)) begin
      return mem_words[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic word_t shadow_word(input word_t addr);
    word_t a;
    a = {addr[31:2], 2'b00};
    if (shadow_words.exists(a)) begin
      return shadow_words[a];
    end
    return fill_word(a);
  endfunction

  function automatic block_t shadow_block(input word_t blk_addr);
    block_t b;
    for (int i = 0; i < 4; i++) begin
      b[32*i +: 32] = shadow_word(blk_addr + word_t'(4 * i));
    end
    return b;
  endfunction

  // Reference cache: hit, victim and write-back, then LRU and shadow update
  function automatic exp_t predict_access(input string name, input word_t addr,
                                          input logic rw, input word_t wdata);
    exp_t             e;
    int               set;
    int               way;
    int               used;
    logic [TAG_W-1:0] tag;
    set         = int'(addr[OFF_W +: SET_BITS]);
    tag         = addr[31 -: TAG_W];
    way         = 0;
    e.name      = name;
    e.addr      = addr;
    e.rw        = rw;
    e.hit       = 1'b0;
    e.wb        = 1'b0;
    e.wb_addr   = '0;
    e.wb_blk    = '0;
    e.fill_addr = addr & ~word_t'(15);
    for (int w = 0; w < 4; w++) begin
      if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
        e.hit = 1'b1;
        way   = w;
      end
    end
    if (!e.hit) begin
      for (int w = 0; w < 4; w++) begin
        if (ref_age[set][w] == OLDEST_AGE) way = w;   // LRU victim
      end
      if (ref_valid[set][way] && ref_dirty[set][way]) begin
        e.wb      = 1'b1;
        e.wb_addr = (word_t'(ref_tag[set][way]) << (SET_BITS + OFF_W)) | (word_t'(set) << OFF_W);
        e.wb_blk  = shadow_block(e.wb_addr);
      end
    end
    used = ref_age[set][way];
    for (int w = 0; w < 4; w++) begin
      if (w == way) begin
        ref_age[set][w] = 0;
      end else if (ref_age[set][w] < used) begin
        ref_age[set][w]++;
      end
    end
    ref_valid[set][way] = 1'b1;
    ref_tag[set][way]   = tag;
    if (rw) begin
      ref_dirty[set][way] = 1'b1;
      shadow_words[{addr[31:2], 2'b00}] = wdata;
    end else if (!e.hit) begin
      ref_dirty[set][way] = 1'b0;   // Fresh clean refill
    end
    e.rdata = shadow_word(addr);
    return e;
  endfunction

  // Issue one request from a falling edge and wait for its response
  task automatic run_access(input string name, input word_t addr, input logic rw,
                            input word_t wdata);
    exp_t e;
    while (!cpu_req_ready) @(negedge clk);
    e = predict_access(name, addr, rw, wdata);
    exp_q.push_back(e);
    cpu_req_enable = 1'b1;
    cpu_req_rw     = rw;
    cpu_req_addr   = addr;
    cpu_req_datain = wdata;
    @(negedge clk);
    cpu_req_enable = 1'b0;
    cpu_req_addr   = ~addr;    // Garbage after acceptance
    cpu_req_datain = ~wdata;
    while (!cpu_res_ready) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic check_response(input exp_t e);
    int    n_xfers;
    xfer_t x;
    n_checks++;
    if (!e.rw && cpu_res_dataout !== e.rdata) begin
      $display("FAIL %s: read of %h expected %h actual %h",
               e.name, e.addr, e.rdata, cpu_res_dataout);
      data_errors++;
    end
    if (e.hit && busy_cycles != 1) begin
      $display("FAIL %s: hit latency expected 1 actual %0d", e.name, busy_cycles);
      proto_errors++;
    end
    if (!e.hit && busy_cycles < 3) begin
      $display("FAIL %s: miss latency expected at least 3 actual %0d", e.name, busy_cycles);
      proto_errors++;
    end
    n_xfers = e.hit ? 0 : (e.wb ? 2 : 1);
    if (xfer_q.size() != n_xfers) begin
      $display("FAIL %s: memory transfers for %h expected %0d actual %0d",
               e.name, e.addr, n_xfers, xfer_q.size());
      mem_errors++;
    end else if (n_xfers > 0) begin
      if (e.wb) begin
        x = xfer_q[0];
        if (x.rw !== 1'b1 || x.addr !== e.wb_addr) begin
          $display("FAIL %s: write-back address expected %h actual %h (rw %b)",
                   e.name, e.wb_addr, x.addr, x.rw);
          mem_errors++;
        end
        if (x.data !== e.wb_blk) begin
          $display("FAIL %s: write-back data expected %h actual %h", e.name, e.wb_blk, x.data);
          mem_errors++;
        end
      end
      x = xfer_q[n_xfers-1];        // Refill comes last
      if (x.rw !== 1'b0 || x.addr !== e.fill_addr) begin
        $display("FAIL %s: refill address expected %h actual %h (rw %b)",
                 e.name, e.fill_addr, x.addr, x.rw);
        mem_errors++;
      end
    end
    xfer_q.delete();
  endtask

  // Memory model with random stalls
  always @(negedge clk) begin
    if (mem_req_ready) begin
      mem_req_ready  = 1'b0;
      mem_req_datain = '0;
    end else if (mem_req_enable) begin
      if (!in_xfer) begin
        in_xfer    = 1'b1;
        mem_rng    = xorshift32(mem_rng);
        stall_left = int'(mem_rng[1:0]);
        held_addr  = mem_req_addr;
        held_rw    = mem_req_rw;
      end else if (mem_req_addr !== held_addr || mem_req_rw !== held_rw) begin
        $display("Memory request changed while waiting for ready at %0t", $time);
        proto_errors++;
      end
      if (stall_left == 0) begin
        if (mem_req_addr[3:0] != 4'h0) begin
          $display("Memory address %h is not block aligned", mem_req_addr);
          proto_errors++;
        end
        cap.rw   = mem_req_rw;
        cap.addr = mem_req_addr;
        cap.data = mem_req_dataout;
        xfer_q.push_back(cap);
        for (int i = 0; i < 4; i++) begin
          if (mem_req_rw) begin
            mem_words[mem_req_addr + word_t'(4 * i)] = mem_req_dataout[32*i +: 32];
          end else begin
            mem_req_datain[32*i +: 32] = mem_word(mem_req_addr + word_t'(4 * i));
          end
        end
        mem_req_ready = 1'b1;
        in_xfer       = 1'b0;
      end else begin
        stall_left--;
      end
    end
  end

  // Response checker
  always @(negedge clk) begin
    exp_t e;
    if (cpu_req_ready) begin
      busy_cycles = 0;
    end else begin
      busy_cycles++;
    end
    if (rst_n && cpu_res_ready) begin
      if (exp_q.size() == 0) begin
        $display("Response seen at %0t with no request outstanding", $time);
        proto_errors++;
      end else begin
        e = exp_q.pop_front();
        check_response(e);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    word_t r;
    word_t addr;
    logic  rw;
    int    total;
    rst_n          = 1'b0;
    cpu_req_enable = 1'b0;
    cpu_req_rw     = 1'b0;
    cpu_req_addr   = '0;
    cpu_req_datain = '0;
    mem_req_datain = '0;
    mem_req_ready  = 1'b0;
    stim_rng       = 32'd68041;
    mem_rng        = xorshift32(32'd68041);
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < 4; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
        ref_age[s][w]   = w;   // Reset ages 0 to 3
      end
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    run_access("cold_read_miss", 32'h0000_1234, 1'b0, '0);
    run_access("read_hit", 32'h0000_1234, 1'b0, '0);

    run_access("write_hit_read", 32'h0000_1238, 1'b1, 32'hCAFE_F00D);
    run_access("write_hit_read", 32'h0000_1238, 1'b0, '0);
    run_access("write_hit_read", 32'h0000_1230, 1'b0, '0);
    run_access("write_hit_read", 32'h0000_1234, 1'b0, '0);
    run_access("write_hit_read", 32'h0000_123C, 1'b0, '0);

    // Five tags into set 5, the fifth evicts the first
    for (int t = 1; t <= 5; t++) begin
      run_access("lru_writeback", (word_t'(t) << 8) | 32'h50, 1'b1, 32'h1000_0000 + t);
    end
    run_access("lru_writeback", 32'h0000_0154, 1'b0, '0);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      stim_rng = xorshift32(stim_rng);
      r        = stim_rng;
      addr     = (word_t'(int'(r[7:0]) % 6 + 8'h40) << 8)
                 | (word_t'(int'(r[15:8]) % 3) << OFF_W)
                 | (word_t'(r[17:16]) << 2);
      rw       = r[20];
      stim_rng = xorshift32(stim_rng);
      run_access("random_traffic", addr, rw, stim_rng);
    end

    total = data_errors + mem_errors + proto_errors;
    $display("Checks %0d, data errors %0d, memory errors %0d, protocol errors %0d",
             n_checks, data_errors, mem_errors, proto_errors);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
  parameter int SET_BITS = 4,
  localparam int TAG_W = cache_pkg::WORD_W - SET_BITS
                         - cache_pkg::WORD_OFF_W - cache_pkg::BYTE_OFF_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cpu_req_enable,
  output logic              cpu_req_ready,
  input  logic              cpu_req_rw,
  input  cache_pkg::word_t  cpu_req_addr,
  input  cache_pkg::word_t  cpu_req_datain,
  output logic              cpu_res_ready,
  output cache_pkg::word_t  cpu_res_dataout,
  output logic              mem_req_enable,
  output logic              mem_req_rw,
  output cache_pkg::word_t  mem_req_addr,
  output cache_pkg::block_t mem_req_dataout,
  input  cache_pkg::block_t mem_req_datain,
  input  logic              mem_req_ready
);

  import cache_pkg::*;

  // Controller to store and datapath
  logic                  rd_en;
  logic [SET_BITS-1:0]   rd_index;
  logic                  wr_en;
  logic                  age_wr_en;
  logic [TAG_W-1:0]      req_tag;
  logic [WORD_OFF_W-1:0] req_word;
  logic                  req_rw;
  word_t                 req_wdata;
  logic                  refill_load;

  // Store read outputs
  way_mask_t                       rd_valid;
  way_mask_t                       rd_dirty;
  age_vec_t                        rd_age;
  logic [NUM_WAYS-1:0][TAG_W-1:0]  rd_tag;
  block_t [NUM_WAYS-1:0]           rd_data;

  // Way selection results
  logic             hit;
  way_mask_t        hit_way;
  way_mask_t        victim_way;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  way_mask_t        wr_way;
  age_vec_t         new_ages;
  block_t           wr_data;
  logic             wr_dirty;

  cache_ctrl_fsm #(.SET_BITS(SET_BITS)) i_ctrl (
    .clk, .rst_n,
    .cpu_req_enable, .cpu_req_ready, .cpu_req_rw, .cpu_req_addr, .cpu_req_datain,
    .cpu_res_ready,
    .mem_req_enable, .mem_req_rw, .mem_req_addr, .mem_req_ready,
    .rd_en, .rd_index, .wr_en, .age_wr_en,
    .req_tag, .req_word, .req_rw, .req_wdata, .refill_load,
    .hit, .victim_dirty, .victim_tag
  );

  cache_line_store #(.SET_BITS(SET_BITS)) i_store (
    .clk, .rst_n,
    .rd_en, .rd_index, .rd_valid, .rd_dirty, .rd_age, .rd_tag, .rd_data,
    .wr_en, .age_wr_en, .wr_way, .wr_tag(req_tag), .wr_data, .wr_dirty, .new_ages
  );

  way_select #(.SET_BITS(SET_BITS)) i_sel (
    .rd_valid, .rd_dirty, .rd_tag, .rd_age, .req_tag,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .wr_way, .new_ages
  );

  line_builder i_build (
    .clk, .rst_n, .refill_load, .mem_req_datain, .rd_data,
    .hit, .hit_way, .victim_way, .req_rw, .req_word, .req_wdata,
    .wr_data, .wr_dirty, .mem_req_dataout, .cpu_res_dataout
  );

endmodule

// File: hdl/cache_ctrl_fsm.sv
`timescale 1ns/1ps

module cache_ctrl_fsm #(
  parameter int SET_BITS = 4,
  localparam int TAG_W = cache_pkg::WORD_W - SET_BITS
                         - cache_pkg::WORD_OFF_W - cache_pkg::BYTE_OFF_W
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            cpu_req_enable,
  output logic                            cpu_req_ready,
  input  logic                            cpu_req_rw,
  input  cache_pkg::word_t                cpu_req_addr,
  input  cache_pkg::word_t                cpu_req_datain,
  output logic                            cpu_res_ready,
  output logic                            mem_req_enable,
  output logic                            mem_req_rw,
  output cache_pkg::word_t                mem_req_addr,
  input  logic                            mem_req_ready,
  output logic                            rd_en,
  output logic [SET_BITS-1:0]             rd_index,
  output logic                            wr_en,
  output logic                            age_wr_en,
  output logic [TAG_W-1:0]                req_tag,
  output logic [cache_pkg::WORD_OFF_W-1:0] req_word,
  output logic                            req_rw,
  output cache_pkg::word_t                req_wdata,
  output logic                            refill_load,
  input  logic                            hit,
  input  logic                            victim_dirty,
  input  logic [TAG_W-1:0]                victim_tag
);

  import cache_pkg::*;

  localparam int OFF_W = WORD_OFF_W + BYTE_OFF_W;   // Block offset in bytes

  cache_state_e        state;
  cache_state_e        state_nxt;
  logic                accept;
  logic [SET_BITS-1:0] req_index;

  assign cpu_req_ready = (state == IDLE);
  assign accept        = cpu_req_enable && cpu_req_ready;

  // Store read starts on the acceptance edge
  assign rd_en    = accept;
  assign rd_index = cpu_req_addr[OFF_W +: SET_BITS];

  // Request registers
  always_ff @(posedge clk) begin
    if (accept) begin
      req_index <= cpu_req_addr[OFF_W +: SET_BITS];
      req_tag   <= cpu_req_addr[WORD_W-1 -: TAG_W];
      req_word  <= cpu_req_addr[BYTE_OFF_W +: WORD_OFF_W];
      req_rw    <= cpu_req_rw;
      req_wdata <= cpu_req_datain;   // CPU drops it after acceptance
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cpu_req_enable) begin
          state_nxt = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_nxt = IDLE;
        end else if (victim_dirty) begin
          state_nxt = WRITEBACK;
        end else begin
          state_nxt = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_req_ready) begin
          state_nxt = REFILL;
        end
      end
      REFILL: begin
        if (mem_req_ready) begin
          state_nxt = UPDATE;
        end
      end
      UPDATE: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // Memory port
  assign mem_req_enable = (state == WRITEBACK) || (state == REFILL);
  assign mem_req_rw     = (state == WRITEBACK);
  assign mem_req_addr   = (state == WRITEBACK) ? {victim_tag, req_index, {OFF_W{1'b0}}}
                                               : {req_tag, req_index, {OFF_W{1'b0}}};
  assign refill_load    = (state == REFILL) && mem_req_ready;

  // Line writes, age updates and the CPU response
  assign cpu_res_ready = ((state == LOOKUP) && hit) || (state == UPDATE);
  assign age_wr_en     = cpu_res_ready;   // Every access touches the ages
  assign wr_en         = ((state == LOOKUP) && hit && req_rw) || (state == UPDATE);

  // Memory request held until accepted
  a_mem_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mem_req_enable && !mem_req_ready)
      |=> (mem_req_enable && $stable(mem_req_addr) && $stable(mem_req_rw))
  );

  // Response is a single pulse that hands control back to IDLE
  a_res_pulse_to_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    cpu_res_ready |=> (!cpu_res_ready && (state == IDLE))
  );

endmodule

// File: hdl/line_builder.sv
`timescale 1ns/1ps

module line_builder (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        refill_load,
  input  cache_pkg::block_t                           mem_req_datain,
  input  cache_pkg::block_t [cache_pkg::NUM_WAYS-1:0] rd_data,
  input  logic                                        hit,
  input  cache_pkg::way_mask_t                        hit_way,
  input  cache_pkg::way_mask_t                        victim_way,
  input  logic                                        req_rw,
  input  logic [cache_pkg::WORD_OFF_W-1:0]            req_word,
  input  cache_pkg::word_t                            req_wdata,
  output cache_pkg::block_t                           wr_data,
  output logic                                        wr_dirty,
  output cache_pkg::block_t                           mem_req_dataout,
  output cache_pkg::word_t                            cpu_res_dataout
);

  import cache_pkg::*;

  block_t refill_q;   // Block fetched from memory
  block_t hit_blk;
  block_t base_blk;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refill_q <= '0;
    end else if (refill_load) begin
      refill_q <= mem_req_datain;
    end
  end

  // Way data muxes, masks are one-hot
  always_comb begin
    hit_blk         = '0;
    mem_req_dataout = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_way[w]) begin
        hit_blk = hit_blk | rd_data[w];
      end
      if (victim_way[w]) begin
        mem_req_dataout = mem_req_dataout | rd_data[w];   // Write-back block
      end
    end
  end

  assign base_blk = hit ? hit_blk : refill_q;

  // Merge the CPU word on writes
  always_comb begin
    wr_data = base_blk;
    if (req_rw) begin
      wr_data[req_word] = req_wdata;
    end
  end

  assign wr_dirty        = req_rw;
  assign cpu_res_dataout = base_blk[req_word];

endmodule

// File: hdl/way_select.sv
`timescale 1ns/1ps

module way_select #(
  parameter int SET_BITS = 4,
  localparam int TAG_W = cache_pkg::WORD_W - SET_BITS
                         - cache_pkg::WORD_OFF_W - cache_pkg::BYTE_OFF_W
) (
  input  cache_pkg::way_mask_t                      rd_valid,
  input  cache_pkg::way_mask_t                      rd_dirty,
  input  logic [cache_pkg::NUM_WAYS-1:0][TAG_W-1:0] rd_tag,
  input  cache_pkg::age_vec_t                       rd_age,
  input  logic [TAG_W-1:0]                          req_tag,
  output logic                                      hit,
  output cache_pkg::way_mask_t                      hit_way,
  output cache_pkg::way_mask_t                      victim_way,
  output logic                                      victim_dirty,
  output logic [TAG_W-1:0]                          victim_tag,
  output cache_pkg::way_mask_t                      wr_way,
  output cache_pkg::age_vec_t                       new_ages
);

  import cache_pkg::*;

  age_t used_age;   // Previous age of the way being touched

  // Tag compare and LRU victim per way
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way[w]    = rd_valid[w] && (rd_tag[w] == req_tag);
      victim_way[w] = (rd_age[w] == age_t'(AGE_OLDEST));
    end
  end

  assign hit          = |hit_way;
  assign victim_dirty = |(victim_way & rd_valid & rd_dirty);   // Needs write-back
  assign wr_way       = hit ? hit_way : victim_way;

  always_comb begin
    victim_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim_way[w]) begin
        victim_tag = victim_tag | rd_tag[w];
      end
    end
  end

  // LRU age update
  // Touched way goes to 0, younger ways age by one, older ways keep their age
  always_comb begin
    used_age = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_way[w]) begin
        used_age = rd_age[w];
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_way[w]) begin
        new_ages[w] = '0;
      end else if (rd_age[w] < used_age) begin
        new_ages[w] = rd_age[w] + 1'b1;
      end else begin
        new_ages[w] = rd_age[w];
      end
    end
  end

endmodule

// File: hdl/cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store #(
  parameter int SET_BITS = 4,
  localparam int TAG_W = cache_pkg::WORD_W - SET_BITS
                         - cache_pkg::WORD_OFF_W - cache_pkg::BYTE_OFF_W
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        rd_en,
  input  logic [SET_BITS-1:0]                         rd_index,
  output cache_pkg::way_mask_t                        rd_valid,
  output cache_pkg::way_mask_t                        rd_dirty,
  output cache_pkg::age_vec_t                         rd_age,
  output logic [cache_pkg::NUM_WAYS-1:0][TAG_W-1:0]   rd_tag,
  output cache_pkg::block_t [cache_pkg::NUM_WAYS-1:0] rd_data,
  input  logic                                        wr_en,
  input  logic                                        age_wr_en,
  input  cache_pkg::way_mask_t                        wr_way,
  input  logic [TAG_W-1:0]                            wr_tag,
  input  cache_pkg::block_t                           wr_data,
  input  logic                                        wr_dirty,
  input  cache_pkg::age_vec_t                         new_ages
);

  import cache_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  way_mask_t          valid_mem [NUM_SETS];
  way_mask_t          dirty_mem [NUM_SETS];
  age_vec_t           age_mem   [NUM_SETS];
  logic [TAG_W-1:0]   tag_mem   [NUM_SETS][NUM_WAYS];
  block_t             data_mem  [NUM_SETS][NUM_WAYS];
  logic [SET_BITS-1:0] idx_q;   // Set of the last read, also the write target

  // Valid, dirty and age state, cleared by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        dirty_mem[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          age_mem[s][w] <= age_t'(w);   // Way 3 starts as the oldest
        end
      end
      idx_q    <= '0;
      rd_valid <= '0;
      rd_dirty <= '0;
      rd_age   <= '0;
    end else begin
      if (rd_en) begin
        idx_q    <= rd_index;
        rd_valid <= valid_mem[rd_index];
        rd_dirty <= dirty_mem[rd_index];
        rd_age   <= age_mem[rd_index];
      end
      if (wr_en) begin
        valid_mem[idx_q] <= valid_mem[idx_q] | wr_way;
        dirty_mem[idx_q] <= (dirty_mem[idx_q] & ~wr_way) | (wr_dirty ? wr_way : '0);
      end
      if (age_wr_en) begin
        age_mem[idx_q] <= new_ages;   // Whole set at once
      end
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        rd_tag[w]  <= tag_mem[rd_index][w];
        rd_data[w] <= data_mem[rd_index][w];
      end
    end
    if (wr_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_way[w]) begin
          tag_mem[idx_q][w]  <= wr_tag;
          data_mem[idx_q][w] <= wr_data;
        end
      end
    end
  end

  // Line write must target exactly one way
  a_wr_way_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> $onehot(wr_way)
  );

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

  // Word and block geometry
  parameter int WORD_W          = 32;
  parameter int WORDS_PER_BLOCK = 4;
  parameter int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
  parameter int BYTE_OFF_W      = 2;   // Byte within a word
  parameter int WORD_OFF_W      = 2;   // Word within a block

  // Associativity and LRU ages
  parameter int NUM_WAYS   = 4;
  parameter int AGE_W      = 2;
  parameter int AGE_OLDEST = 3;        // Age of the least recently used way

  typedef logic [WORD_W-1:0] word_t;

  // Block as words, so a word offset indexes it directly
  typedef logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] block_t;

  typedef logic [NUM_WAYS-1:0] way_mask_t;

  typedef logic [AGE_W-1:0] age_t;

  // Ages of all ways of one set, way 0 in the low bits
  typedef logic [NUM_WAYS-1:0][AGE_W-1:0] age_vec_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    WRITEBACK = 3'd2,
    REFILL    = 3'd3,
    UPDATE    = 3'd4
  } cache_state_e;

endpackage
